// ==== source/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// word address, bits 23 down to 1
`define ST_ADDR_W 23

// chipset and upload data bus
`define ST_DATA_W 16

// memory size select field
`define ST_MEM_SIZE_W 3
`define ST_MEM_512K 3'd0
`define ST_MEM_1M 3'd1
`define ST_MEM_2M 3'd2
`define ST_MEM_4M 3'd3
`define ST_MEM_8M 3'd4
`define ST_MEM_14M 3'd5

// viking window at $c00000, address bits 23:18
`define ST_VIKING_BASE_LO 6'b110000
// steroids viking window at $e80000, address bits 23:19
`define ST_VIKING_BASE_HI 5'b11101

// upload to $fc0000 and up means a 192k tos, bits 23:18
`define ST_TOS_HI_CODE 6'b111111
// upload to $e00000 region means a normal tos, bits 23:20
`define ST_TOS_E_CODE 4'he

// rom2 remap prefixes above the low 17 address bits
`define ST_ROM_BASE_E 6'b111000
`define ST_ROM_BASE_F 6'b111111

`endif

// ==== source/stmem_pkg.sv ====
`include "mem_consts.svh"

package stmem_pkg;

	// installed ram size, same codes as the core config word
	typedef enum logic [`ST_MEM_SIZE_W-1:0] {
		MEM_512K = `ST_MEM_512K,
		MEM_1M   = `ST_MEM_1M,
		MEM_2M   = `ST_MEM_2M,
		MEM_4M   = `ST_MEM_4M,
		MEM_8M   = `ST_MEM_8M,
		MEM_14M  = `ST_MEM_14M
	} mem_size_e;

	// machine config, ste plus mste means steroids
	typedef struct packed {
		mem_size_e size;
		logic      ste;
		logic      mste;
		logic      viking_en;
	} mem_cfg_t;

	// decoded bus slot flags
	typedef struct packed {
		logic cpu_precycle;
		logic cpu_cycle;
		logic video_cycle;
		logic video_precycle;
	} slot_t;

	// chipset side of the ram bus
	typedef struct packed {
		logic [`ST_ADDR_W:1]    ram_a;
		logic                   uds;
		logic                   lds;
		logic                   we_n;
		logic                   ras_n;
		logic [`ST_DATA_W-1:0]  din;
	} chip_bus_t;

	// tos/cartridge upload port
	typedef struct packed {
		logic                   download;
		logic                   strobe;
		logic [`ST_ADDR_W:1]    addr;
		logic [`ST_DATA_W-1:0]  data;
	} dl_bus_t;

	// viking video fetch
	typedef struct packed {
		logic [`ST_ADDR_W:1] vaddr;
		logic                read;
		logic                active;
	} video_rd_t;

	// one registered request towards the sdram controller
	typedef struct packed {
		logic                   valid;
		logic                   we;
		logic                   uds;
		logic                   lds;
		logic [`ST_ADDR_W:1]    addr;
		logic [`ST_DATA_W-1:0]  data;
	} sdram_req_t;

	// rom read port
	typedef struct packed {
		logic                oe;
		logic [`ST_ADDR_W:1] addr;
	} rom_req_t;

endpackage

// ==== source/bus_slot_decode.sv ====
`timescale 1ns/10ps

module bus_slot_decode (
	input  logic                clk_32,
	input  logic                xsint,
	input  logic                mhz8_en_i,
	input  logic                as_n_i,
	input  logic                turbo_req_i,
	input  logic [1:0]          bus_cycle_i,
	input  stmem_pkg::mem_cfg_t mem_cfg_i,
	output stmem_pkg::slot_t    slot_o
);

	logic steroids;
	logic turbo_bus;

	// steroids always runs the fast bus
	assign steroids = mem_cfg_i.ste & mem_cfg_i.mste;

	// bus mode may only change while no access is running
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			turbo_bus <= 1'b0;
		end else if (mhz8_en_i && as_n_i) begin
			turbo_bus <= turbo_req_i | steroids;
		end
	end

	// slot 0 is always the cpu pre-cycle
	// turbo gives the cpu two slots and moves video to slot 3
	always_comb begin
		slot_o.cpu_precycle   = (bus_cycle_i == 2'd0);
		slot_o.cpu_cycle      = (bus_cycle_i == 2'd1) || (turbo_bus && bus_cycle_i == 2'd2);
		slot_o.video_cycle    = turbo_bus ? (bus_cycle_i == 2'd3) : (bus_cycle_i == 2'd2);
		slot_o.video_precycle = turbo_bus ? (bus_cycle_i == 2'd1) : (bus_cycle_i == 2'd3);
	end

	// slots only move on after an 8 MHz enable
	a_cycle_steps_on_enable: assert property (
		@(posedge clk_32) disable iff (!xsint)
		!$past(mhz8_en_i) |-> (bus_cycle_i == $past(bus_cycle_i))
	);

endmodule

// ==== source/ram_window.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module ram_window (
	input  stmem_pkg::chip_bus_t chip_i,
	input  stmem_pkg::mem_cfg_t  mem_cfg_i,
	output logic                 ram_en_o
);

	logic steroids;
	logic size_hit;
	logic viking_mem_ok;
	logic viking_enable;
	logic viking_hit;

	assign steroids = mem_cfg_i.ste & mem_cfg_i.mste;

	// address prefix has to be clear above the installed size
	always_comb begin
		size_hit      = 1'b0;
		viking_mem_ok = 1'b1;
		case (mem_cfg_i.size)
			stmem_pkg::MEM_512K: size_hit = (chip_i.ram_a[23:19] == 5'b00000);
			stmem_pkg::MEM_1M:   size_hit = (chip_i.ram_a[23:20] == 4'b0000);
			stmem_pkg::MEM_2M:   size_hit = (chip_i.ram_a[23:21] == 3'b000);
			stmem_pkg::MEM_4M:   size_hit = (chip_i.ram_a[23:22] == 2'b00);
			stmem_pkg::MEM_8M:   size_hit = ~chip_i.ram_a[23];
			stmem_pkg::MEM_14M: begin
				// everything but $e00000 and up
				size_hit      = ~(chip_i.ram_a[23] & chip_i.ram_a[22] & chip_i.ram_a[21]);
				viking_mem_ok = 1'b0;
			end
			default: begin
				// unused size codes map nothing
				size_hit      = 1'b0;
				viking_mem_ok = 1'b0;
			end
		endcase
	end

	// viking fits below 8M, steroids moves it up to $e80000
	assign viking_enable = (mem_cfg_i.viking_en & viking_mem_ok) | steroids;

	always_comb begin
		if (steroids) begin
			viking_hit = (chip_i.ram_a[23:19] == `ST_VIKING_BASE_HI);
		end else begin
			viking_hit = (chip_i.ram_a[23:18] == `ST_VIKING_BASE_LO);
		end
	end

	assign ram_en_o = size_hit | (viking_enable & viking_hit);

endmodule

// ==== source/rom_mapper.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module rom_mapper (
	input  logic                 clk_32,
	input  logic                 xsint,
	input  stmem_pkg::dl_bus_t   dl_i,
	input  logic                 rom2_n_i,
	input  logic                 rom_n_i,
	input  logic [`ST_ADDR_W:1]  mbus_a_i,
	output stmem_pkg::rom_req_t  rom_req_o
);

	// set while a 192k tos image sits in the rom area
	logic tos192k;

	// image type follows the upload address
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dl_i.download) begin
			if (dl_i.addr[23:18] == `ST_TOS_HI_CODE) begin
				tos192k <= 1'b1;
			end else if (dl_i.addr[23:20] == `ST_TOS_E_CODE) begin
				tos192k <= 1'b0;
			end
		end
	end

	// rom2 is the tos rom, placed where the image was uploaded
	// cartridge and other roms keep the bus address
	always_comb begin
		rom_req_o.oe = ~rom_n_i;
		if (!rom2_n_i) begin
			if (tos192k) begin
				rom_req_o.addr = {`ST_ROM_BASE_F, mbus_a_i[17:1]};
			end else begin
				rom_req_o.addr = {`ST_ROM_BASE_E, mbus_a_i[17:1]};
			end
		end else begin
			rom_req_o.addr = mbus_a_i;
		end
	end

endmodule

// ==== source/download_writer.sv ====
`timescale 1ns/10ps

module download_writer (
	input  logic               clk_32,
	input  logic               xsint,
	input  logic               mhz8_en_i,
	input  stmem_pkg::slot_t   slot_i,
	input  stmem_pkg::dl_bus_t dl_i,
	input  logic               dl_wr_taken_i,
	output logic               dl_wr_pending_o
);

	logic strobe_d;
	logic pending;

	assign dl_wr_pending_o = pending;

	// strobe toggles once per upload word
	// sampled only in the cpu pre-cycle
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d <= 1'b0;
			pending  <= 1'b0;
		end else begin
			// mux took the write in the cpu slot
			if (dl_wr_taken_i) begin
				pending <= 1'b0;
			end
			if (slot_i.cpu_precycle && mhz8_en_i) begin
				strobe_d <= dl_i.strobe;
				if (dl_i.download && (dl_i.strobe != strobe_d)) begin
					pending <= 1'b1;
				end
			end
		end
	end

	// the mux only takes what was announced
	a_taken_needs_pending: assert property (
		@(posedge clk_32) disable iff (!xsint)
		dl_wr_taken_i |-> dl_wr_pending_o
	);

endmodule

// ==== source/sdram_request_mux.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module sdram_request_mux (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  mhz8_en_i,
	input  stmem_pkg::slot_t      slot_i,
	input  stmem_pkg::chip_bus_t  chip_i,
	input  logic                  ram_en_i,
	input  stmem_pkg::video_rd_t  video_i,
	input  stmem_pkg::dl_bus_t    dl_i,
	input  logic                  dl_wr_pending_i,
	output logic                  dl_wr_taken_o,
	output stmem_pkg::sdram_req_t sdram_req_o
);

	logic                  ras_n_d;
	logic                  ras_fall;
	logic                  dl_sel;
	logic                  video_sel;
	logic                  req_nxt;
	logic                  we_nxt;
	logic                  uds_nxt;
	logic                  lds_nxt;
	logic [`ST_ADDR_W:1]   addr_nxt;
	logic [`ST_DATA_W-1:0] data_nxt;
	logic                  valid_q;
	logic                  we_q;
	logic                  uds_q;
	logic                  lds_q;
	logic [`ST_ADDR_W:1]   addr_q;
	logic [`ST_DATA_W-1:0] data_q;

	// ras going low, zero address is a refresh
	assign ras_fall = ras_n_d & ~chip_i.ras_n & (|chip_i.ram_a);

	// upload owns the cpu slot, viking owns the video slot
	assign dl_sel    = slot_i.cpu_cycle & dl_i.download;
	assign video_sel = slot_i.video_cycle & video_i.active & video_i.read;

	// one write per pending word, on the slot strobe
	assign dl_wr_taken_o = dl_sel & mhz8_en_i & dl_wr_pending_i;

	always_comb begin
		if (dl_sel) begin
			req_nxt  = dl_wr_taken_o;
			we_nxt   = 1'b1;
			uds_nxt  = 1'b1;
			lds_nxt  = 1'b1;
			addr_nxt = dl_i.addr;
			data_nxt = dl_i.data;
		end else if (video_sel) begin
			// full word read, once per video slot
			req_nxt  = mhz8_en_i;
			we_nxt   = 1'b0;
			uds_nxt  = 1'b1;
			lds_nxt  = 1'b1;
			addr_nxt = video_i.vaddr;
			data_nxt = chip_i.din;
		end else begin
			req_nxt  = ras_fall & ram_en_i;
			we_nxt   = ~chip_i.we_n;
			uds_nxt  = chip_i.uds;
			lds_nxt  = chip_i.lds;
			addr_nxt = chip_i.ram_a;
			data_nxt = chip_i.din;
		end
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;
			valid_q <= 1'b0;
		end else begin
			ras_n_d <= chip_i.ras_n;
			valid_q <= req_nxt;
		end
	end

	// payload only moves with a new request
	always_ff @(posedge clk_32) begin
		if (req_nxt) begin
			we_q   <= we_nxt;
			uds_q  <= uds_nxt;
			lds_q  <= lds_nxt;
			addr_q <= addr_nxt;
			data_q <= data_nxt;
		end
	end

	assign sdram_req_o = '{
		valid: valid_q,
		we:    we_q,
		uds:   uds_q,
		lds:   lds_q,
		addr:  addr_q,
		data:  data_q
	};

	// slot timing leaves a gap between any two requests
	a_valid_single: assert property (
		@(posedge clk_32) disable iff (!xsint)
		sdram_req_o.valid |=> !sdram_req_o.valid
	);

endmodule

// ==== source/st_memory_mux.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module st_memory_mux (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  mhz8_en_i,
	input  logic                  as_n_i,
	input  logic                  turbo_req_i,
	input  logic                  rom2_n_i,
	input  logic                  rom_n_i,
	input  logic [1:0]            bus_cycle_i,
	input  stmem_pkg::mem_cfg_t   mem_cfg_i,
	input  stmem_pkg::chip_bus_t  chip_i,
	input  stmem_pkg::video_rd_t  video_i,
	input  stmem_pkg::dl_bus_t    dl_i,
	input  logic [`ST_ADDR_W:1]   mbus_a_i,
	output stmem_pkg::sdram_req_t sdram_req_o,
	output stmem_pkg::rom_req_t   rom_req_o
);

	stmem_pkg::slot_t slot;
	logic             ram_en;
	logic             dl_wr_pending;
	logic             dl_wr_taken;

	// four slot bus timing
	bus_slot_decode i_bus_slot_decode (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.mhz8_en_i   (mhz8_en_i),
		.as_n_i      (as_n_i),
		.turbo_req_i (turbo_req_i),
		.bus_cycle_i (bus_cycle_i),
		.mem_cfg_i   (mem_cfg_i),
		.slot_o      (slot)
	);

	// installed ram and viking window
	ram_window i_ram_window (
		.chip_i    (chip_i),
		.mem_cfg_i (mem_cfg_i),
		.ram_en_o  (ram_en)
	);

	// tos image type and rom2 remap
	rom_mapper i_rom_mapper (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.dl_i      (dl_i),
		.rom2_n_i  (rom2_n_i),
		.rom_n_i   (rom_n_i),
		.mbus_a_i  (mbus_a_i),
		.rom_req_o (rom_req_o)
	);

	// upload strobe to pending write
	download_writer i_download_writer (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.slot_i          (slot),
		.dl_i            (dl_i),
		.dl_wr_taken_i   (dl_wr_taken),
		.dl_wr_pending_o (dl_wr_pending)
	);

	// source select and request register
	sdram_request_mux i_sdram_request_mux (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en_i       (mhz8_en_i),
		.slot_i          (slot),
		.chip_i          (chip_i),
		.ram_en_i        (ram_en),
		.video_i         (video_i),
		.dl_i            (dl_i),
		.dl_wr_pending_i (dl_wr_pending),
		.dl_wr_taken_o   (dl_wr_taken),
		.sdram_req_o     (sdram_req_o)
	);

endmodule

// ==== tb/tb_st_memory_mux.sv ====
`timescale 1ns/10ps

`include "mem_consts.svh"

module tb_st_memory_mux;

	localparam int WAIT_LIMIT = 48;
	localparam int MAX_VEC    = 40;

	logic                  clk_32;
	logic                  xsint;
	logic                  as_n;
	logic                  turbo_req;
	logic                  rom2_n;
	logic                  rom_n;
	logic [1:0]            slot_div = 2'd0;
	logic [1:0]            bus_cycle = 2'd0;
	logic                  mhz8_en;
	logic [`ST_ADDR_W:1]   mbus_a;
	stmem_pkg::mem_cfg_t   mem_cfg;
	stmem_pkg::chip_bus_t  chip;
	stmem_pkg::video_rd_t  video;
	stmem_pkg::dl_bus_t    dl;
	stmem_pkg::sdram_req_t sdram_req;
	stmem_pkg::rom_req_t   rom_req;

	// five words per vector: kind, config, address, data, expected
	logic [31:0] pat_mem [0:MAX_VEC*5-1];

	st_memory_mux i_st_memory_mux (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.mhz8_en_i   (mhz8_en),
		.as_n_i      (as_n),
		.turbo_req_i (turbo_req),
		.rom2_n_i    (rom2_n),
		.rom_n_i     (rom_n),
		.bus_cycle_i (bus_cycle),
		.mem_cfg_i   (mem_cfg),
		.chip_i      (chip),
		.video_i     (video),
		.dl_i        (dl),
		.mbus_a_i    (mbus_a),
		.sdram_req_o (sdram_req),
		.rom_req_o   (rom_req)
	);

	initial begin
		clk_32 = 1'b0;
		forever #5 clk_32 = ~clk_32;
	end

	// 8 MHz enable on every fourth clock
	// bus cycle moves on after each enable
	always @(negedge clk_32) begin
		if (slot_div == 2'd3) begin
			bus_cycle <= bus_cycle + 2'd1;
		end
		slot_div <= slot_div + 2'd1;
	end

	assign mhz8_en = (slot_div == 2'd3);

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Simulation failed");
		$fatal(1, "stopped after timeout");
	endtask

	// valid must stay low, one check per cycle
	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk_32);
			check_value("sdram_req_o.valid", 32'(sdram_req.valid), 32'd0);
		end
	endtask

	// chipset read, ras edge in the first cycle
	task automatic run_chip_access(input logic [5:0] cfg, input logic [23:0] addr,
		input logic [15:0] data, input logic accept);
		mem_cfg    = stmem_pkg::mem_cfg_t'(cfg);
		chip.ram_a = addr[23:1];
		chip.uds   = 1'b1;
		chip.lds   = 1'b1;
		chip.we_n  = 1'b1;
		chip.din   = data;
		chip.ras_n = 1'b0;
		@(negedge clk_32);
		check_value("sdram_req_o.valid", 32'(sdram_req.valid), 32'(accept));
		if (accept) begin
			check_value("sdram_req_o.addr", 32'(sdram_req.addr), 32'(addr[23:1]));
			check_value("sdram_req_o.uds", 32'(sdram_req.uds), 32'd1);
			check_value("sdram_req_o.lds", 32'(sdram_req.lds), 32'd1);
			check_value("sdram_req_o.we", 32'(sdram_req.we), 32'd0);
		end
		chip.ras_n = 1'b1;
		expect_idle(3);
	endtask

	// one strobe toggle means one word to write
	task automatic run_upload(input logic [5:0] cfg, input logic [23:0] addr,
		input logic [15:0] data);
		int n;
		mem_cfg     = stmem_pkg::mem_cfg_t'(cfg);
		dl.download = 1'b1;
		dl.addr     = addr[23:1];
		dl.data     = data;
		dl.strobe   = ~dl.strobe;
		n = 0;
		@(negedge clk_32);
		while (!sdram_req.valid) begin
			if (n == WAIT_LIMIT) begin
				report_timeout("the upload write request");
			end
			n++;
			@(negedge clk_32);
		end
		check_value("sdram_req_o.we", 32'(sdram_req.we), 32'd1);
		check_value("sdram_req_o.uds", 32'(sdram_req.uds), 32'd1);
		check_value("sdram_req_o.lds", 32'(sdram_req.lds), 32'd1);
		check_value("sdram_req_o.addr", 32'(sdram_req.addr), 32'(addr[23:1]));
		check_value("sdram_req_o.data", 32'(sdram_req.data), 32'(data));
		expect_idle(1);
		dl.download = 1'b0;
	endtask

	// rom port is combinational, look one cycle later
	task automatic run_rom_read(input logic [5:0] cfg, input logic [23:0] addr,
		input logic [23:0] exp_addr);
		mem_cfg = stmem_pkg::mem_cfg_t'(cfg);
		rom2_n  = 1'b0;
		rom_n   = 1'b0;
		mbus_a  = addr[23:1];
		@(posedge clk_32);
		@(negedge clk_32);
		check_value("rom_req_o.oe", 32'(rom_req.oe), 32'd1);
		check_value("rom_req_o.addr", 32'(rom_req.addr), 32'(exp_addr[23:1]));
		rom2_n = 1'b1;
		rom_n  = 1'b1;
	endtask

	// video fetch and chipset ras edge land on the same video slot
	task automatic run_video_read(input logic [5:0] cfg, input logic [23:0] vaddr,
		input logic [23:0] chip_addr);
		int n;
		mem_cfg = stmem_pkg::mem_cfg_t'(cfg);
		n = 0;
		@(posedge clk_32);
		// slot 2 one cycle before its enable
		while (!(bus_cycle == 2'd2 && slot_div == 2'd2)) begin
			if (n == WAIT_LIMIT) begin
				report_timeout("a video slot");
			end
			n++;
			@(posedge clk_32);
		end
		@(negedge clk_32);
		chip.ram_a   = chip_addr[23:1];
		chip.we_n    = 1'b1;
		chip.ras_n   = 1'b0;
		video.vaddr  = vaddr[23:1];
		video.read   = 1'b1;
		video.active = 1'b1;
		@(negedge clk_32);
		check_value("sdram_req_o.valid", 32'(sdram_req.valid), 32'd1);
		check_value("sdram_req_o.addr", 32'(sdram_req.addr), 32'(vaddr[23:1]));
		check_value("sdram_req_o.we", 32'(sdram_req.we), 32'd0);
		video.read   = 1'b0;
		video.active = 1'b0;
		chip.ras_n   = 1'b1;
		expect_idle(1);
	endtask

	initial begin
		int base;
		int vec_count;
		logic [3:0] kind;
		logic done;
		void'($urandom(32'h8b4a));
		xsint     = 1'b0;
		as_n      = 1'b1;
		turbo_req = 1'b0;
		rom2_n    = 1'b1;
		rom_n     = 1'b1;
		mbus_a    = '0;
		mem_cfg   = '0;
		chip      = '0;
		chip.ras_n = 1'b1;
		video     = '0;
		dl        = '0;
		repeat (16) @(negedge clk_32);
		xsint = 1'b1;
		// quiet bus after reset
		expect_idle(8);
		$readmemh("tb/st_memory_mux_patterns.hex", pat_mem);
		vec_count = 0;
		done      = 1'b0;
		while (!done && vec_count < MAX_VEC) begin
			base = vec_count * 5;
			kind = pat_mem[base][3:0];
			case (kind)
				4'h1: run_chip_access(pat_mem[base+1][5:0], pat_mem[base+2][23:0],
					pat_mem[base+3][15:0], pat_mem[base+4][0]);
				4'h2: run_upload(pat_mem[base+1][5:0], pat_mem[base+2][23:0],
					pat_mem[base+3][15:0]);
				4'h3: run_rom_read(pat_mem[base+1][5:0], pat_mem[base+2][23:0],
					pat_mem[base+4][23:0]);
				4'h4: run_video_read(pat_mem[base+1][5:0], pat_mem[base+2][23:0],
					pat_mem[base+4][23:0]);
				4'hf: done = 1'b1;
				default: begin
					$display("pattern file holds an unknown vector kind %h", kind);
					$display("Simulation failed");
					$fatal(1, "bad pattern file");
				end
			endcase
			if (!done) begin
				vec_count++;
				// idle gap with ras high
				repeat (int'($urandom % 32'd4) + 1) @(negedge clk_32);
			end
		end
		if (vec_count == 0) begin
			$display("no vectors were read from the pattern file");
			$display("Simulation failed");
		end else begin
			$display("Simulation completed successfully");
		end
		$finish;
	end

endmodule

// ==== tb/st_memory_mux_patterns.hex ====
// kind cfg addr data expect, cfg = {size[2:0], ste, mste, viking_en}
// kind 1 chipset read (expect 1 taken, 0 dropped), 2 upload, 3 rom2 read, 4 video, f end
1 00 07fffe a501 000001
1 00 080000 a502 000000
1 08 0ffffe a503 000001
1 08 100000 a504 000000
1 10 1ffffe a505 000001
1 10 200000 a506 000000
1 18 3ffffe a507 000001
1 18 400000 a508 000000
1 20 7ffffe a509 000001
1 20 800000 a50a 000000
1 28 dffffe a50b 000001
1 28 e00000 a50c 000000
// viking window checks
1 19 c00000 b001 000001
1 20 c00000 b002 000000
1 21 c00000 b003 000001
1 29 e80000 b004 000000
1 2f e80000 b005 000001
// rom2 remap follows the uploaded tos region
3 18 012346 0000 e12346
2 18 fc0000 5aa5 000000
3 18 012346 0000 fd2346
2 18 e00002 c3c3 000000
3 18 012346 0000 e12346
// video address wins over the chipset address in the last column
4 19 c01000 0000 012340
f 00 000000 0000 000000

// ==== list.f ====
+incdir+source
source/stmem_pkg.sv
source/bus_slot_decode.sv
source/ram_window.sv
source/rom_mapper.sv
source/download_writer.sv
source/sdram_request_mux.sv
source/st_memory_mux.sv
tb/tb_st_memory_mux.sv

// ==== Makefile ====
# Verilator flow for the ST memory multiplexer

VERILATOR ?= verilator
FILE_LIST ?= list.f
TB_TOP    ?= tb_st_memory_mux
RTL_TOP   ?= st_memory_mux
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
